/* all.f */
+incdir+verilog
verilog/spi_pkg.sv
verilog/word_stream.sv
verilog/spi_pin_sync.sv
verilog/spi_slave_register.sv
verilog/word_fifo.sv
verilog/spi_slave_top.sv
verification/spi_slave_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the SPI slave simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f all.f \
    --top-module spi_slave_tb -o spi_slave_sim

./obj_dir/spi_slave_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "Simulation reported a failure, see sim.log"
    exit 1
fi

echo "Simulation finished, see sim.log"

/* verification/spi_slave_tb.sv */
// SPI slave directed testbench
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_slave_tb;

    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RX_WAIT_LIMIT = 100;
    localparam int WORD_BITS = $bits(spi_pkg::spi_word_t);

    logic clock = 1'b0;
    logic reset;
    logic sclk;
    logic ss;
    logic mosi;
    logic miso;
    spi_pkg::spi_len_t spi_transfer_length;
    logic latching_edge;
    logic msb_first;
    logic ss_polarity;
    logic enable;
    spi_pkg::spi_word_t tx_data;
    logic tx_valid;
    logic tx_ready;
    spi_pkg::spi_word_t rx_data;
    logic rx_valid;
    logic rx_ready;
    logic rx_overflow;

    int error_count = 0;
    int cycle_count = 0;
    logic [31:0] lcg_state = 32'h7646_55ba;

    spi_slave_top dut0 (
        .clock              (clock),
        .reset              (reset),
        .sclk               (sclk),
        .ss                 (ss),
        .mosi               (mosi),
        .miso               (miso),
        .spi_transfer_length(spi_transfer_length),
        .latching_edge      (latching_edge),
        .msb_first          (msb_first),
        .ss_polarity        (ss_polarity),
        .enable             (enable),
        .tx_data            (tx_data),
        .tx_valid           (tx_valid),
        .tx_ready           (tx_ready),
        .rx_data            (rx_data),
        .rx_valid           (rx_valid),
        .rx_ready           (rx_ready),
        .rx_overflow        (rx_overflow)
    );

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Run stopped after %0d cycles with tests still running", cycle_count);
            $display("Errors: %0d", error_count);
            $display("Testbench failed");
            $finish;
        end
    end

    // Upper half of the LCG state has the better bits
    function automatic spi_pkg::spi_word_t next_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[31:16];
    endfunction

    function automatic spi_pkg::spi_word_t low_mask(input int length);
        spi_pkg::spi_word_t mask;
        mask = '0;
        for (int i = 0; i < length && i < WORD_BITS; i++) begin
            mask[i] = 1'b1;
        end
        return mask;
    endfunction

    task automatic compare_value(input string name, input spi_pkg::spi_word_t expected,
                                 input spi_pkg::spi_word_t actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic wait_clocks(input int count);
        repeat (count) @(posedge clock);
    endtask

    // Pins go to their idle levels together with the new mode
    task automatic configure(input spi_pkg::spi_len_t length, input logic latch,
                             input logic msb, input logic polarity, input logic en);
        @(posedge clock);
        spi_transfer_length <= length;
        latching_edge <= latch;
        msb_first <= msb;
        ss_polarity <= polarity;
        enable <= en;
        ss <= ~polarity;
        sclk <= latch;
        mosi <= 1'b0;
        wait_clocks(16);
    endtask

    task automatic push_tx(input spi_pkg::spi_word_t word);
        @(posedge clock);
        tx_data <= word;
        tx_valid <= 1'b1;
        @(negedge clock);
        while (!tx_ready) begin
            @(negedge clock);
        end
        @(posedge clock);
        tx_valid <= 1'b0;
    endtask

    // SPI master with 8 clocks per SCLK half period
    task automatic spi_exchange(input spi_pkg::spi_word_t mosi_word, input int length,
                                output spi_pkg::spi_word_t miso_word);
        int pos;
        miso_word = '0;
        @(posedge clock);
        ss <= ss_polarity;
        for (int slot = 0; slot < length; slot++) begin
            pos = msb_first ? length - 1 - slot : slot;
            mosi <= mosi_word[pos];
            wait_clocks(7);
            // Sample just before the capture edge
            @(negedge clock);
            miso_word[pos] = miso;
            @(posedge clock);
            sclk <= ~latching_edge;
            wait_clocks(8);
            sclk <= latching_edge;
        end
        wait_clocks(8);
        ss <= ~ss_polarity;
        wait_clocks(8);
    endtask

    task automatic pop_rx(input spi_pkg::spi_word_t expected);
        int waited;
        waited = 0;
        @(negedge clock);
        while (!rx_valid && waited < RX_WAIT_LIMIT) begin
            @(negedge clock);
            waited++;
        end
        assert (rx_valid) else begin
            error_count++;
            $display("No rx_valid within %0d cycles after the transfer", RX_WAIT_LIMIT);
        end
        if (rx_valid) begin
            compare_value("rx_data", expected, rx_data);
            @(posedge clock);
            rx_ready <= 1'b1;
            @(posedge clock);
            rx_ready <= 1'b0;
        end
    endtask

    task automatic expect_no_rx(input int cycles);
        int seen;
        seen = 0;
        repeat (cycles) begin
            @(negedge clock);
            if (rx_valid) begin
                seen++;
            end
        end
        assert (seen == 0) else begin
            error_count++;
            $display("rx_valid rose although the core was disabled");
        end
    endtask

    // One full exchange with both directions checked
    task automatic exchange_and_check(input int length);
        spi_pkg::spi_word_t tx_word;
        spi_pkg::spi_word_t mosi_word;
        spi_pkg::spi_word_t miso_word;
        spi_pkg::spi_word_t mask;
        tx_word = next_word();
        mosi_word = next_word();
        mask = low_mask(length);
        push_tx(tx_word);
        spi_exchange(mosi_word, length, miso_word);
        compare_value("miso", tx_word & mask, miso_word);
        pop_rx(mosi_word & mask);
    endtask

    task automatic lsb_rising_exchange();
        configure(8'd16, 1'b0, 1'b0, 1'b0, 1'b1);
        exchange_and_check(16);
    endtask

    task automatic falling_edge_active_high();
        configure(8'd16, 1'b1, 1'b0, 1'b1, 1'b1);
        exchange_and_check(16);
    endtask

    task automatic msb_first_exchange();
        configure(8'd16, 1'b0, 1'b1, 1'b0, 1'b1);
        exchange_and_check(16);
    endtask

    task automatic short_word_exchange();
        configure(8'd8, 1'b0, 1'b0, 1'b0, 1'b1);
        exchange_and_check(8);
    endtask

    task automatic disabled_core_keeps_tx();
        spi_pkg::spi_word_t tx_word;
        spi_pkg::spi_word_t mosi_word;
        spi_pkg::spi_word_t miso_word;
        configure(8'd16, 1'b0, 1'b0, 1'b0, 1'b0);
        tx_word = next_word();
        push_tx(tx_word);
        spi_exchange(next_word(), 16, miso_word);
        expect_no_rx(500);
        // The word pushed while disabled goes out first
        configure(8'd16, 1'b0, 1'b0, 1'b0, 1'b1);
        mosi_word = next_word();
        spi_exchange(mosi_word, 16, miso_word);
        compare_value("miso", tx_word, miso_word);
        pop_rx(mosi_word);
        mosi_word = next_word();
        spi_exchange(mosi_word, 16, miso_word);
        compare_value("miso", '0, miso_word);
        pop_rx(mosi_word);
    endtask

    task automatic rx_overflow_drain();
        spi_pkg::spi_word_t sent [5];
        spi_pkg::spi_word_t miso_word;
        configure(8'd16, 1'b0, 1'b0, 1'b0, 1'b1);
        for (int i = 0; i < 5; i++) begin
            sent[i] = next_word();
            spi_exchange(sent[i], 16, miso_word);
            compare_value("miso", '0, miso_word);
        end
        wait_clocks(4);
        @(negedge clock);
        compare_value("rx_overflow", 1, rx_overflow);
        for (int i = 0; i < 4; i++) begin
            pop_rx(sent[i]);
        end
        // Fifth word was dropped
        wait_clocks(4);
        @(negedge clock);
        compare_value("rx_valid", 0, rx_valid);
    endtask

    // A full transmit FIFO holds off the host
    task automatic tx_full_stall();
        for (int i = 0; i < `SPI_FIFO_DEPTH; i++) begin
            push_tx(next_word());
        end
        @(negedge clock);
        compare_value("tx_ready", 0, tx_ready);
    endtask

    initial begin
        reset = 1'b0;
        sclk = 1'b0;
        ss = 1'b1;
        mosi = 1'b0;
        spi_transfer_length = 8'd16;
        latching_edge = 1'b0;
        msb_first = 1'b0;
        ss_polarity = 1'b0;
        enable = 1'b0;
        tx_data = '0;
        tx_valid = 1'b0;
        rx_ready = 1'b0;
        wait_clocks(4);
        reset <= 1'b1;
        wait_clocks(4);

        lsb_rising_exchange();
        falling_edge_active_high();
        msb_first_exchange();
        short_word_exchange();
        disabled_core_keeps_tx();
        rx_overflow_drain();
        tx_full_stall();

        $display("Errors: %0d", error_count);
        if (error_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* verilog/spi_cfg.svh */
// SPI slave configuration macros
`ifndef SPI_CFG_SVH
`define SPI_CFG_SVH

// Shift register and data word width
`define SPI_WORD_WIDTH 16

// Width of the transfer length field and bit counter
`define SPI_LEN_WIDTH 8

// Entries in each word FIFO
`define SPI_FIFO_DEPTH 4

// Flip-flops in each pin synchronizer
`define SPI_SYNC_STAGES 2

`endif

/* verilog/spi_pin_sync.sv */
// SPI pin synchronizer and edge detector
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_pin_sync (
    input  logic clock,
    input  logic reset,
    input  logic sclk,
    input  logic ss,
    input  logic mosi,
    input  logic latching_edge,
    input  logic ss_polarity,
    output logic ss_active,
    output logic ss_start,
    output logic ss_end,
    output logic capture_edge,
    output logic shift_edge,
    output logic mosi_bit
);

    localparam int STAGES = `SPI_SYNC_STAGES;

    logic [STAGES-1:0] sclk_sync;
    logic [STAGES-1:0] ss_sync;
    logic [STAGES-1:0] mosi_sync;

    logic ss_n;
    logic ss_cond;
    logic sclk_cond;
    logic ss_del;
    logic sclk_del;
    logic polarity_del;

    // Internal select is active low, pin is flipped for active-high parts
    assign ss_n = ss_sync[STAGES-1] ^ ss_polarity;
    assign ss_cond = ~ss_n;

    // Capture always happens on the rising edge of the conditioned clock
    assign sclk_cond = sclk_sync[STAGES-1] ^ latching_edge;

    always_ff @(posedge clock) begin
        if (!reset) begin
            sclk_sync <= '0;
            ss_sync <= '0;
            mosi_sync <= '0;
            sclk_del <= 1'b0;
            // Looks already selected so reset does not fake a select edge
            ss_del <= 1'b1;
            polarity_del <= 1'b0;
            ss_active <= 1'b0;
            ss_start <= 1'b0;
            ss_end <= 1'b0;
            capture_edge <= 1'b0;
            shift_edge <= 1'b0;
            mosi_bit <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[STAGES-2:0], sclk};
            ss_sync <= {ss_sync[STAGES-2:0], ss};
            mosi_sync <= {mosi_sync[STAGES-2:0], mosi};

            sclk_del <= sclk_cond;
            ss_del <= ss_cond;
            polarity_del <= ss_polarity;

            ss_active <= ss_cond;
            // A polarity flip is not a select
            ss_start <= ss_cond & ~ss_del & (ss_polarity == polarity_del);
            ss_end <= ~ss_cond & ss_del;
            capture_edge <= sclk_cond & ~sclk_del;
            shift_edge <= ~sclk_cond & sclk_del;
            mosi_bit <= mosi_sync[STAGES-1];
        end
    end

endmodule

/* verilog/spi_pkg.sv */
// SPI slave shared types
`include "spi_cfg.svh"

package spi_pkg;

    // One data word as shifted on the bus
    typedef logic [`SPI_WORD_WIDTH-1:0] spi_word_t;

    // Transfer length and bit counter
    typedef logic [`SPI_LEN_WIDTH-1:0] spi_len_t;

    // Occupancy count, must hold the value of the depth itself
    typedef logic [$clog2(`SPI_FIFO_DEPTH + 1)-1:0] fifo_count_t;

    // Shift core states
    typedef enum logic [1:0] {
        spi_idle,
        spi_transfer,
        spi_wait_deassert
    } spi_state_t;

endpackage

/* verilog/spi_slave_register.sv */
// SPI slave shift core
`timescale 1ns/1ps
`include "spi_cfg.svh"

module spi_slave_register (
    input  logic clock,
    input  logic reset,
    input  logic ss_start,
    input  logic ss_end,
    input  logic capture_edge,
    input  logic shift_edge,
    input  logic mosi_bit,
    input  spi_pkg::spi_len_t spi_transfer_length,
    input  logic msb_first,
    input  logic enable,
    output logic miso,
    word_stream.sink data_in,
    word_stream.source data_out
);

    localparam int IDX_W = $clog2(`SPI_WORD_WIDTH);

    spi_pkg::spi_state_t state;
    spi_pkg::spi_len_t bit_count;
    spi_pkg::spi_len_t last_bit;
    logic [IDX_W-1:0] bit_index;

    spi_pkg::spi_word_t tx_word;
    spi_pkg::spi_word_t tx_next;
    spi_pkg::spi_word_t rx_shift;
    spi_pkg::spi_word_t rx_word;
    logic rx_valid;

    logic start_transfer;
    logic word_done;

    function automatic spi_pkg::spi_word_t reverse_word(input spi_pkg::spi_word_t word);
        spi_pkg::spi_word_t result;
        for (int i = 0; i < `SPI_WORD_WIDTH; i++) begin
            result[i] = word[`SPI_WORD_WIDTH-1-i];
        end
        return result;
    endfunction

    assign last_bit = spi_transfer_length - 1'b1;
    assign bit_index = bit_count[IDX_W-1:0];

    assign start_transfer = (state == spi_pkg::spi_idle) && enable && ss_start;
    // Deselect in wait state with no word pending yet
    assign word_done = (state == spi_pkg::spi_wait_deassert) && !rx_valid && ss_end;

    // Takes a transmit word only at the select strobe
    assign data_in.ready = start_transfer;

    assign data_out.data = rx_word;
    assign data_out.valid = rx_valid;
    assign data_out.last = 1'b1;

    // Empty transmit FIFO means the master reads zeros
    always_comb begin
        if (!data_in.valid) begin
            tx_next = '0;
        end else if (msb_first) begin
            tx_next = reverse_word(data_in.data);
        end else begin
            tx_next = data_in.data;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= spi_pkg::spi_idle;
            bit_count <= '0;
            miso <= 1'b0;
            rx_valid <= 1'b0;
        end else begin
            case (state)
                spi_pkg::spi_idle: begin
                    if (start_transfer) begin
                        state <= spi_pkg::spi_transfer;
                        bit_count <= '0;
                        miso <= tx_next[0];
                    end
                end
                spi_pkg::spi_transfer: begin
                    if (ss_end) begin
                        // Master gave up mid-word, nothing to report
                        state <= spi_pkg::spi_idle;
                    end else if (capture_edge) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == last_bit) begin
                            state <= spi_pkg::spi_wait_deassert;
                        end
                    end else if (shift_edge) begin
                        miso <= tx_word[bit_index];
                    end
                end
                spi_pkg::spi_wait_deassert: begin
                    if (rx_valid) begin
                        if (data_out.ready) begin
                            rx_valid <= 1'b0;
                            state <= spi_pkg::spi_idle;
                        end
                    end else if (ss_end) begin
                        rx_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= spi_pkg::spi_idle;
                end
            endcase
        end
    end

    // Word registers
    always_ff @(posedge clock) begin
        if (start_transfer) begin
            tx_word <= tx_next;
            rx_shift <= '0;
        end
        if (state == spi_pkg::spi_transfer && !ss_end && capture_edge) begin
            rx_shift[bit_index] <= mosi_bit;
        end
        if (word_done) begin
            rx_word <= msb_first ? reverse_word(rx_shift) : rx_shift;
        end
    end

endmodule

/* verilog/spi_slave_top.sv */
// SPI slave peripheral top level
`timescale 1ns/1ps

module spi_slave_top (
    input  logic clock,
    input  logic reset,
    input  logic sclk,
    input  logic ss,
    input  logic mosi,
    output logic miso,
    input  spi_pkg::spi_len_t spi_transfer_length,
    input  logic latching_edge,
    input  logic msb_first,
    input  logic ss_polarity,
    input  logic enable,
    input  spi_pkg::spi_word_t tx_data,
    input  logic tx_valid,
    output logic tx_ready,
    output spi_pkg::spi_word_t rx_data,
    output logic rx_valid,
    input  logic rx_ready,
    output logic rx_overflow
);

    logic ss_start;
    logic ss_end;
    logic capture_edge;
    logic shift_edge;
    logic mosi_bit;

    // Host side streams
    word_stream host_to_tx_fifo ();
    word_stream rx_fifo_to_host ();

    // Internal streams around the core
    word_stream tx_fifo_to_core ();
    word_stream core_to_rx_fifo ();

    // Host writes are single words
    assign host_to_tx_fifo.data = tx_data;
    assign host_to_tx_fifo.valid = tx_valid;
    assign host_to_tx_fifo.last = 1'b1;
    assign tx_ready = host_to_tx_fifo.ready;

    assign rx_data = rx_fifo_to_host.data;
    assign rx_valid = rx_fifo_to_host.valid;
    assign rx_fifo_to_host.ready = rx_ready;

    spi_pin_sync pin_sync (
        .clock        (clock),
        .reset        (reset),
        .sclk         (sclk),
        .ss           (ss),
        .mosi         (mosi),
        .latching_edge(latching_edge),
        .ss_polarity  (ss_polarity),
        .ss_active    (),
        .ss_start     (ss_start),
        .ss_end       (ss_end),
        .capture_edge (capture_edge),
        .shift_edge   (shift_edge),
        .mosi_bit     (mosi_bit)
    );

    spi_slave_register core (
        .clock              (clock),
        .reset              (reset),
        .ss_start           (ss_start),
        .ss_end             (ss_end),
        .capture_edge       (capture_edge),
        .shift_edge         (shift_edge),
        .mosi_bit           (mosi_bit),
        .spi_transfer_length(spi_transfer_length),
        .msb_first          (msb_first),
        .enable             (enable),
        .miso               (miso),
        .data_in            (tx_fifo_to_core.sink),
        .data_out           (core_to_rx_fifo.source)
    );

    // Host is stalled while the transmit side is full
    word_fifo tx_fifo (
        .clock         (clock),
        .reset         (reset),
        .push_side     (host_to_tx_fifo.sink),
        .pop_side      (tx_fifo_to_core.source),
        .drop_when_full(1'b0),
        .overflow      ()
    );

    // The master cannot be stalled, so full means dropped words
    word_fifo rx_fifo (
        .clock         (clock),
        .reset         (reset),
        .push_side     (core_to_rx_fifo.sink),
        .pop_side      (rx_fifo_to_host.source),
        .drop_when_full(1'b1),
        .overflow      (rx_overflow)
    );

endmodule

/* verilog/word_fifo.sv */
// Word stream FIFO
`timescale 1ns/1ps
`include "spi_cfg.svh"

module word_fifo #(
    parameter int DEPTH = `SPI_FIFO_DEPTH
) (
    input  logic clock,
    input  logic reset,
    word_stream.sink push_side,
    word_stream.source pop_side,
    input  logic drop_when_full,
    output logic overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    spi_pkg::spi_word_t data_mem [DEPTH];
    logic last_mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    spi_pkg::fifo_count_t count;

    logic full;
    logic empty;
    logic push_fire;
    logic write_en;
    logic read_en;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full = (count == spi_pkg::fifo_count_t'(DEPTH));
    assign empty = (count == '0);

    // Drop mode never pushes back, a word arriving while full is lost
    assign push_side.ready = drop_when_full | ~full;
    assign push_fire = push_side.valid & push_side.ready;
    assign write_en = push_fire & ~full;

    assign pop_side.valid = ~empty;
    assign pop_side.data = data_mem[rd_ptr];
    assign pop_side.last = last_mem[rd_ptr];
    assign read_en = pop_side.valid & pop_side.ready;

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            overflow <= 1'b0;
        end else begin
            if (write_en) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (read_en) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (write_en && !read_en) begin
                count <= count + 1'b1;
            end else if (read_en && !write_en) begin
                count <= count - 1'b1;
            end
            // Sticky until reset
            if (push_fire && full) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (write_en) begin
            data_mem[wr_ptr] <= push_side.data;
            last_mem[wr_ptr] <= push_side.last;
        end
    end

endmodule

/* verilog/word_stream.sv */
// Valid/ready word stream
`timescale 1ns/1ps

interface word_stream;

    spi_pkg::spi_word_t data;
    logic valid;
    logic ready;
    // Final word of a burst
    logic last;

    modport source (
        output data,
        output valid,
        output last,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        output ready
    );

endinterface
